// ==== src/cache_pkg.sv ====
package cache_pkg;

    // ************************************************************************
    // geometry
    // ************************************************************************
    localparam int num_sets       = 8;     // sets per way.
    localparam int num_ways       = 2;     // two-way set associative.
    localparam int word_bits      = 32;    // cpu data width.
    localparam int line_bits      = 128;   // memory data width, one line.
    localparam int words_per_line = 4;     // line_bits / word_bits.
    localparam int offset_bits    = 4;     // byte offset inside a line.
    localparam int index_bits     = 3;     // log2 of num_sets.
    localparam int tag_bits       = 25;    // what is left of the address.

    // ************************************************************************
    // address fields and data widths
    // ************************************************************************
    typedef logic [tag_bits+index_bits+offset_bits-1:0] addr_t;  // byte address.
    typedef logic [tag_bits-1:0]                        tag_t;
    typedef logic [index_bits-1:0]                      index_t;
    typedef logic [$clog2(words_per_line)-1:0]          word_sel_t;  // word in line.
    typedef logic [word_bits-1:0]                       word_t;
    typedef logic [word_bits/8-1:0]                     byte_sel_t;
    typedef logic [line_bits-1:0]                       line_t;
    typedef logic [line_bits/8-1:0]                     line_sel_t;  // memory byte selects.

    // ************************************************************************
    // wishbone, cpu side (slave port of the cache)
    // ************************************************************************
    typedef struct packed {
        logic      cyc;    // bus cycle.
        logic      stb;    // strobe.
        logic      we;     // 1 = write.
        addr_t     adr;    // byte address.
        byte_sel_t sel;    // byte lanes.
        word_t     dat;    // write data.
    } wb_cpu_req_t;

    typedef struct packed {
        logic  ack;        // one cycle per request.
        word_t dat;        // read data.
    } wb_cpu_rsp_t;

    // ************************************************************************
    // wishbone, memory side (master port of the cache)
    // ************************************************************************
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;     // high for a writeback.
        addr_t     adr;    // always line aligned.
        line_sel_t sel;    // whole line.
        line_t     dat;    // victim line.
    } wb_mem_req_t;

    typedef struct packed {
        logic  ack;
        line_t dat;        // fill line.
    } wb_mem_rsp_t;

    // control states.
    typedef enum logic [2:0] {
        idle,
        compare,
        write_back,
        fill,
        respond
    } ctrl_state_t;

    // source of the line written into a way.
    typedef enum logic {
        cpu_merge,
        memory_line
    } data_src_t;

endpackage

// ==== src/cache_way.sv ====
`timescale 1ns/1ps

module cache_way (
    input  logic              clk,
    input  logic              rst_n,
    input  cache_pkg::index_t index,      // set being accessed.
    input  logic              we,         // write this way at the edge.
    input  cache_pkg::tag_t   tag_in,
    input  cache_pkg::line_t  line_in,
    input  logic              dirty_in,
    output cache_pkg::tag_t   tag_out,
    output logic              valid_out,
    output logic              dirty_out,
    output cache_pkg::line_t  line_out
);

    // ************************************************************************
    // storage
    // ************************************************************************
    cache_pkg::tag_t  tag_mem  [cache_pkg::num_sets];   // tag per set.
    cache_pkg::line_t line_mem [cache_pkg::num_sets];   // line data per set.

    logic [cache_pkg::num_sets-1:0] valid_bits;         // line holds data.
    logic [cache_pkg::num_sets-1:0] dirty_bits;         // line differs from memory.

    // status bits, cleared on reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;                    // cold cache.
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[index] <= 1'b1;           // any write makes it valid.
            dirty_bits[index] <= dirty_in;       // cpu merge sets, fill clears.
        end
    end

    // tag and line arrays.
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[index]  <= tag_in;
            line_mem[index] <= line_in;
        end
    end

    // ************************************************************************
    // read port, combinational on index
    // ************************************************************************
    assign tag_out   = tag_mem[index];
    assign valid_out = valid_bits[index];
    assign dirty_out = dirty_bits[index];
    assign line_out  = line_mem[index];

endmodule

// ==== src/cache_datapath.sv ====
`timescale 1ns/1ps

module cache_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   way_sel,      // way to write or evict.
    input  cache_pkg::data_src_t   data_src,     // merge or fill.
    input  logic                   tag_bypass,   // victim tag on memory address.
    input  logic                   load,         // write selected way.
    input  logic                   load_lru,     // update lru of the set.
    input  cache_pkg::wb_cpu_req_t cpu_req,
    input  cache_pkg::line_t       mem_line,     // fill data.
    output logic                   hit_0,
    output logic                   hit_1,
    output logic                   dirty,        // victim is dirty.
    output logic                   lru,          // victim way.
    output cache_pkg::word_t       cpu_data,
    output cache_pkg::addr_t       mem_adr,
    output cache_pkg::line_sel_t   mem_sel,
    output cache_pkg::line_t       mem_data
);

    // ************************************************************************
    // address split
    // ************************************************************************
    cache_pkg::tag_t      cpu_tag;
    cache_pkg::index_t    cpu_index;
    cache_pkg::word_sel_t cpu_word;

    assign cpu_tag   = cpu_req.adr[31 -: cache_pkg::tag_bits];
    assign cpu_index = cpu_req.adr[cache_pkg::offset_bits +: cache_pkg::index_bits];
    assign cpu_word  = cpu_req.adr[2 +: $bits(cache_pkg::word_sel_t)];  // above byte bits.

    // per-way read results.
    cache_pkg::tag_t          way_tag   [cache_pkg::num_ways];
    logic                     way_valid [cache_pkg::num_ways];
    logic                     way_dirty [cache_pkg::num_ways];
    cache_pkg::line_t         way_line  [cache_pkg::num_ways];
    logic [cache_pkg::num_ways-1:0] way_we;

    cache_pkg::line_t write_line;    // line going into the selected way.
    logic             write_dirty;

    assign way_we[0] = load & ~way_sel;
    assign way_we[1] = load &  way_sel;

    cache_way way_0 (
        .clk,
        .rst_n,
        .index     (cpu_index),
        .we        (way_we[0]),
        .tag_in    (cpu_tag),      // fills and merges both use the cpu tag.
        .line_in   (write_line),
        .dirty_in  (write_dirty),
        .tag_out   (way_tag[0]),
        .valid_out (way_valid[0]),
        .dirty_out (way_dirty[0]),
        .line_out  (way_line[0])
    );

    cache_way way_1 (
        .clk,
        .rst_n,
        .index     (cpu_index),
        .we        (way_we[1]),
        .tag_in    (cpu_tag),
        .line_in   (write_line),
        .dirty_in  (write_dirty),
        .tag_out   (way_tag[1]),
        .valid_out (way_valid[1]),
        .dirty_out (way_dirty[1]),
        .line_out  (way_line[1])
    );

    // ************************************************************************
    // hit compare and lru
    // ************************************************************************
    logic [cache_pkg::num_sets-1:0] lru_bits;   // points at the way not used last.

    assign hit_0 = way_valid[0] & (way_tag[0] == cpu_tag);
    assign hit_1 = way_valid[1] & (way_tag[1] == cpu_tag);
    assign lru   = lru_bits[cpu_index];
    assign dirty = way_dirty[lru];               // dirty bit of the victim.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (load_lru) begin
            lru_bits[cpu_index] <= ~way_sel;     // the other way goes next.
        end
    end

    // ************************************************************************
    // cpu word select and byte merge
    // ************************************************************************
    cache_pkg::word_t [cache_pkg::words_per_line-1:0] hit_words;   // read view.
    cache_pkg::word_t [cache_pkg::words_per_line-1:0] sel_words;   // merge view.

    assign hit_words = hit_1 ? way_line[1] : way_line[0];
    assign cpu_data  = hit_words[cpu_word];

    always_comb begin
        cache_pkg::word_t merged;
        sel_words = way_line[way_sel];
        merged    = sel_words[cpu_word];
        for (int b = 0; b < cache_pkg::word_bits / 8; b++) begin
            if (cpu_req.sel[b])
                merged[8*b +: 8] = cpu_req.dat[8*b +: 8];   // new byte lane.
        end
        sel_words[cpu_word] = merged;
        if (data_src == cache_pkg::cpu_merge) begin
            write_line  = sel_words;
            write_dirty = 1'b1;                  // now differs from memory.
        end else begin
            write_line  = mem_line;
            write_dirty = 1'b0;                  // fresh from memory.
        end
    end

    // ************************************************************************
    // memory side
    // ************************************************************************
    assign mem_adr  = tag_bypass ? {way_tag[way_sel], cpu_index, {cache_pkg::offset_bits{1'b0}}}
                                 : {cpu_tag, cpu_index, {cache_pkg::offset_bits{1'b0}}};
    assign mem_sel  = '1;                        // always the whole line.
    assign mem_data = way_line[way_sel];         // victim for writeback.

endmodule

// ==== src/cache_control.sv ====
`timescale 1ns/1ps

module cache_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hit_0,
    input  logic                 hit_1,
    input  logic                 dirty,        // victim needs writeback.
    input  logic                 lru,          // victim way.
    input  logic                 cpu_request,  // cyc and stb.
    input  logic                 cpu_we,
    input  logic                 mem_ack,
    output logic                 way_sel,
    output cache_pkg::data_src_t data_src,
    output logic                 tag_bypass,
    output logic                 load,
    output logic                 load_lru,
    output logic                 cpu_ack,
    output logic                 mem_request,
    output logic                 mem_we
);

    cache_pkg::ctrl_state_t state_q;
    cache_pkg::ctrl_state_t state_d;

    logic hit;

    assign hit = hit_0 | hit_1;

    // ************************************************************************
    // state register
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n)
            state_q <= cache_pkg::idle;
        else
            state_q <= state_d;
    end

    // ************************************************************************
    // next state
    // ************************************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::idle: begin
                if (cpu_request)
                    state_d = cache_pkg::compare;
            end
            cache_pkg::compare: begin
                if (hit)
                    state_d = cache_pkg::respond;
                else if (dirty)
                    state_d = cache_pkg::write_back;   // victim first.
                else
                    state_d = cache_pkg::fill;
            end
            cache_pkg::write_back: begin
                if (mem_ack)
                    state_d = cache_pkg::fill;
            end
            cache_pkg::fill: begin
                if (mem_ack)
                    state_d = cache_pkg::compare;      // hits next time.
            end
            cache_pkg::respond: begin
                state_d = cache_pkg::idle;
            end
            default: begin
                state_d = cache_pkg::idle;
            end
        endcase
    end

    // ************************************************************************
    // outputs, decoded from state
    // ************************************************************************
    always_comb begin
        way_sel     = lru;                       // victim unless a hit.
        data_src    = cache_pkg::cpu_merge;
        tag_bypass  = 1'b0;
        load        = 1'b0;
        load_lru    = 1'b0;
        cpu_ack     = 1'b0;
        mem_request = 1'b0;
        mem_we      = 1'b0;
        case (state_q)
            cache_pkg::compare: begin
                if (hit) begin
                    way_sel  = hit_1;            // the hit way.
                    load     = cpu_we;           // merge write data.
                    load_lru = 1'b1;
                end
            end
            cache_pkg::write_back: begin
                tag_bypass  = 1'b1;              // victim address.
                mem_request = 1'b1;
                mem_we      = 1'b1;
            end
            cache_pkg::fill: begin
                data_src    = cache_pkg::memory_line;
                mem_request = 1'b1;
                load        = mem_ack;           // line lands on the ack edge.
            end
            cache_pkg::respond: begin
                cpu_ack = 1'b1;
            end
            default: begin
                cpu_ack = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/cache.sv ====
`timescale 1ns/1ps

module cache (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::wb_cpu_req_t cpu_req,   // from the cpu.
    output cache_pkg::wb_cpu_rsp_t cpu_rsp,
    output cache_pkg::wb_mem_req_t mem_req,   // to memory.
    input  cache_pkg::wb_mem_rsp_t mem_rsp
);

    logic                 cpu_request;   // valid cpu cycle.
    logic                 mem_request;   // drives memory cyc and stb.

    // datapath and control interconnect.
    logic                 way_sel;
    cache_pkg::data_src_t data_src;
    logic                 tag_bypass;
    logic                 load;
    logic                 load_lru;
    logic                 hit_0;
    logic                 hit_1;
    logic                 dirty;
    logic                 lru;

    assign cpu_request = cpu_req.cyc & cpu_req.stb;
    assign mem_req.cyc = mem_request;
    assign mem_req.stb = mem_request;

    cache_datapath u_datapath (
        .clk,
        .rst_n,
        .way_sel,
        .data_src,
        .tag_bypass,
        .load,
        .load_lru,
        .cpu_req,
        .mem_line (mem_rsp.dat),
        .hit_0,
        .hit_1,
        .dirty,
        .lru,
        .cpu_data (cpu_rsp.dat),
        .mem_adr  (mem_req.adr),
        .mem_sel  (mem_req.sel),
        .mem_data (mem_req.dat)
    );

    cache_control u_control (
        .clk,
        .rst_n,
        .hit_0,
        .hit_1,
        .dirty,
        .lru,
        .cpu_request,
        .cpu_we   (cpu_req.we),
        .mem_ack  (mem_rsp.ack),
        .way_sel,
        .data_src,
        .tag_bypass,
        .load,
        .load_lru,
        .cpu_ack  (cpu_rsp.ack),
        .mem_request,
        .mem_we   (mem_req.we)
    );

endmodule

// ==== test/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter int latency = 3                       // cycles from request to ack.
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::wb_mem_req_t mem_req,
    output cache_pkg::wb_mem_rsp_t mem_rsp
);

    cache_pkg::line_t store [cache_pkg::addr_t];    // lines written back so far.
    int               wait_cnt;                     // cycles spent on this request.

    // untouched memory, every word holds its own address.
    function automatic cache_pkg::line_t preload(cache_pkg::addr_t adr);
        cache_pkg::line_t l;
        for (int w = 0; w < cache_pkg::words_per_line; w++)
            l[32*w +: 32] = {adr[31:4], w[1:0], 2'b00};
        return l;
    endfunction

    initial mem_rsp = '0;

    always @(posedge clk) begin
        if (!rst_n) begin
            mem_rsp  <= '0;
            wait_cnt <= 0;
        end else begin
            mem_rsp.ack <= 1'b0;                    // one cycle only.
            if (mem_req.cyc && mem_req.stb && !mem_rsp.ack) begin
                if (wait_cnt == latency - 1) begin
                    mem_rsp.ack <= 1'b1;
                    wait_cnt    <= 0;
                    if (mem_req.we)
                        store[mem_req.adr] = mem_req.dat;        // writeback.
                    else if (store.exists(mem_req.adr))
                        mem_rsp.dat <= store[mem_req.adr];
                    else
                        mem_rsp.dat <= preload(mem_req.adr);     // cold line.
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

// ==== test/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::wb_cpu_req_t cpu_req,
    input  cache_pkg::wb_cpu_rsp_t cpu_rsp,
    input  cache_pkg::wb_mem_req_t mem_req,
    input  cache_pkg::wb_mem_rsp_t mem_rsp,
    output int                     checks,
    output int                     errors
);

    // ************************************************************************
    // shadow memory and cache model
    // ************************************************************************
    logic [7:0]       shadow [cache_pkg::addr_t];   // bytes written by the cpu.
    cache_pkg::tag_t  model_tag   [cache_pkg::num_sets][cache_pkg::num_ways];
    logic             model_valid [cache_pkg::num_sets][cache_pkg::num_ways];
    logic             model_dirty [cache_pkg::num_sets][cache_pkg::num_ways];
    logic             model_lru   [cache_pkg::num_sets];   // next victim.

    logic             busy;          // cpu request in flight.
    logic             pred_hit;
    logic             pred_wb;       // dirty victim expected.
    cache_pkg::addr_t victim_adr;
    int               cycle;
    int               start_cycle;   // edge that first sampled the request.
    int               mem_reads;
    int               mem_writes;

    function automatic logic [7:0] byte_at(cache_pkg::addr_t a);
        cache_pkg::addr_t w;
        w = {a[31:2], 2'b00};
        if (shadow.exists(a))
            return shadow[a];
        return w[8*a[1:0] +: 8];                    // preload, word equals address.
    endfunction

    // expected read word.
    function automatic cache_pkg::word_t ref_word(cache_pkg::addr_t a);
        cache_pkg::word_t w;
        for (int b = 0; b < 4; b++)
            w[8*b +: 8] = byte_at({a[31:2], b[1:0]});
        return w;
    endfunction

    function automatic cache_pkg::line_t ref_line(cache_pkg::addr_t a);
        cache_pkg::line_t l;
        for (int b = 0; b < 16; b++)
            l[8*b +: 8] = byte_at({a[31:4], b[3:0]});
        return l;
    endfunction

    task automatic verify(input logic ok, input string what);
        checks++;
        if (!ok) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s", $time, what);
        end
    endtask

    // ************************************************************************
    // bus watcher
    // ************************************************************************
    always @(posedge clk) begin
        cache_pkg::tag_t   tag;
        cache_pkg::index_t idx;
        logic              way;
        if (!rst_n) begin
            busy   = 1'b0;
            cycle  = 0;
            checks = 0;
            errors = 0;
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                model_lru[s] = 1'b0;                // lru starts at way 0.
                for (int w = 0; w < cache_pkg::num_ways; w++) begin
                    model_valid[s][w] = 1'b0;
                    model_dirty[s][w] = 1'b0;
                end
            end
        end else begin
            cycle++;
            if (!busy && (mem_req.cyc || cpu_rsp.ack))
                verify(1'b0, "bus activity with no cpu request");
            if (busy && mem_req.cyc && mem_req.stb && mem_rsp.ack) begin
                verify(mem_req.sel == 16'hffff,
                       $sformatf("memory sel 0x%04h, want the whole line", mem_req.sel));
                if (mem_req.we) begin
                    mem_writes++;
                    verify(pred_wb && mem_reads == 0, "unexpected memory write");
                    verify(mem_req.adr == victim_adr,
                           $sformatf("writeback adr 0x%08h want 0x%08h",
                                     mem_req.adr, victim_adr));
                    verify(mem_req.dat == ref_line(victim_adr),
                           $sformatf("writeback data wrong at 0x%08h", victim_adr));
                end else begin
                    mem_reads++;
                    verify(!pred_hit, "memory read on a predicted hit");
                    verify(!pred_wb || mem_writes == 1, "fill before writeback");
                    verify(mem_req.adr == {cpu_req.adr[31:4], 4'h0},
                           $sformatf("fill adr 0x%08h for cpu adr 0x%08h",
                                     mem_req.adr, cpu_req.adr));
                end
            end
            if (busy && cpu_rsp.ack) begin
                if (pred_hit)
                    verify(cycle - start_cycle == 2,
                           $sformatf("hit ack after %0d cycles", cycle - start_cycle));
                verify(mem_reads == (pred_hit ? 0 : 1) && mem_writes == (pred_wb ? 1 : 0),
                       $sformatf("adr 0x%08h saw %0d reads, %0d writes",
                                 cpu_req.adr, mem_reads, mem_writes));
                if (cpu_req.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (cpu_req.sel[b])
                            shadow[{cpu_req.adr[31:2], b[1:0]}] = cpu_req.dat[8*b +: 8];
                    end
                end else begin
                    verify(cpu_rsp.dat == ref_word(cpu_req.adr),
                           $sformatf("read 0x%08h got 0x%08h want 0x%08h", cpu_req.adr,
                                     cpu_rsp.dat, ref_word(cpu_req.adr)));
                end
                busy = 1'b0;
            end else if (!busy && cpu_req.cyc && cpu_req.stb) begin
                tag      = cpu_req.adr[31:7];
                idx      = cpu_req.adr[6:4];
                pred_hit = 1'b0;
                pred_wb  = 1'b0;
                way      = model_lru[idx];          // victim unless hit.
                for (int w = 0; w < cache_pkg::num_ways; w++) begin
                    if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
                        pred_hit = 1'b1;
                        way      = w[0];
                    end
                end
                if (!pred_hit) begin
                    pred_wb    = model_valid[idx][way] && model_dirty[idx][way];
                    victim_adr = {model_tag[idx][way], idx, 4'h0};
                    model_tag[idx][way]   = tag;
                    model_valid[idx][way] = 1'b1;
                    model_dirty[idx][way] = 1'b0;     // clean after fill.
                end
                if (cpu_req.we)
                    model_dirty[idx][way] = 1'b1;
                model_lru[idx] = ~way;               // other way goes next.
                busy        = 1'b1;
                start_cycle = cycle;
                mem_reads   = 0;
                mem_writes  = 0;
            end
        end
    end

endmodule

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

    localparam int num_directed   = 18;
    localparam int num_random     = 300;
    localparam int num_ops        = num_directed + num_random;
    localparam int mem_latency    = 3;
    localparam int timeout_cycles = num_ops * 40 + 200;   // worst miss well under 40.

    logic                   clk;
    logic                   rst_n;
    cache_pkg::wb_cpu_req_t cpu_req;
    cache_pkg::wb_cpu_rsp_t cpu_rsp;
    cache_pkg::wb_mem_req_t mem_req;
    cache_pkg::wb_mem_rsp_t mem_rsp;
    int                     seed;
    int                     checks;
    int                     errors;

    cache dut (.clk, .rst_n, .cpu_req, .cpu_rsp, .mem_req, .mem_rsp);

    mem_model #(.latency(mem_latency)) memory (.clk, .rst_n, .mem_req, .mem_rsp);

    cache_checker chk (.clk, .rst_n, .cpu_req, .cpu_rsp, .mem_req, .mem_rsp, .checks, .errors);

    initial clk = 1'b0;
    always #4 clk = ~clk;                           // 8 ns period.

    // ************************************************************************
    // cpu side stimulus
    // ************************************************************************
    function automatic cache_pkg::addr_t make_adr(int tag, int set, int word);
        return {tag[24:0], set[2:0], word[1:0], 2'b00};
    endfunction

    task automatic access(input logic we, input cache_pkg::addr_t adr,
                          input cache_pkg::byte_sel_t sel, input cache_pkg::word_t dat);
        @(posedge clk);
        cpu_req.cyc <= 1'b1;
        cpu_req.stb <= 1'b1;
        cpu_req.we  <= we;
        cpu_req.adr <= adr;
        cpu_req.sel <= sel;
        cpu_req.dat <= dat;
        @(posedge clk);
        while (!cpu_rsp.ack)                        // held until ack.
            @(posedge clk);
        cpu_req.cyc <= 1'b0;
        cpu_req.stb <= 1'b0;
    endtask

    task automatic read_word(input cache_pkg::addr_t adr);
        access(1'b0, adr, 4'hf, 32'h0);
    endtask

    task automatic write_bytes(input cache_pkg::addr_t adr, input cache_pkg::byte_sel_t sel,
                               input cache_pkg::word_t dat);
        access(1'b1, adr, sel, dat);
    endtask

    initial begin
        int               r;
        cache_pkg::word_t d;
        seed    = 32'h59e9_907a;
        rst_n   = 1'b0;
        cpu_req = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);                  // quiet bus after reset.
        // cold reads, then a hit in the same line.
        read_word(make_adr(0, 0, 0));
        read_word(make_adr(0, 0, 3));
        read_word(make_adr(1, 5, 2));
        // partial byte writes merge into the old word.
        write_bytes(make_adr(0, 0, 1), 4'b0101, 32'haabb_ccdd);
        read_word(make_adr(0, 0, 1));
        write_bytes(make_adr(0, 0, 1), 4'b1000, 32'h1122_3344);
        read_word(make_adr(0, 0, 1));
        // lru in set 2, A B A C evicts B.
        read_word(make_adr(4, 2, 0));
        read_word(make_adr(5, 2, 0));
        read_word(make_adr(4, 2, 1));
        read_word(make_adr(6, 2, 0));
        read_word(make_adr(4, 2, 2));
        read_word(make_adr(5, 2, 3));
        // dirty victims in set 3.
        write_bytes(make_adr(8, 3, 0), 4'hf, 32'hdead_beef);
        write_bytes(make_adr(9, 3, 2), 4'b0011, 32'h0000_5a5a);
        read_word(make_adr(10, 3, 1));
        read_word(make_adr(8, 3, 0));
        read_word(make_adr(10, 3, 1));
        // random mix, 4 tags over all sets.
        for (int i = 0; i < num_random; i++) begin
            r = $random(seed);
            d = $random(seed);
            access(r[7], make_adr(r & 3, (r >> 2) & 7, (r >> 5) & 3), r[11:8], d);
        end
        repeat (4) @(posedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // watchdog.
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: test did not finish within %0d cycles", timeout_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
src/cache_pkg.sv
src/cache_way.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache.sv
test/mem_model.sv
test/cache_checker.sv
test/cache_tb.sv

// ==== Makefile ====
TOP = cache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
